// ==== sim.f ====
logic/tcm_pkg.sv
logic/tcm_req_if.sv
logic/tcm_bypass_ram.sv
logic/tcm_access_pipe.sv
logic/tcm_rsp_fifo.sv
logic/tcm_top.sv
tests/tb_clkgen.sv
tests/tcm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TCM testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tcm_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF "** PASS **" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

// ==== tests/tcm_tb.sv ====
// TCM testbench
// Credit-tracked directed and random requests, responses checked
// against a reference memory by concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module tcm_tb;

localparam int ADDR_W      = 6;
localparam int RSP_DEPTH   = 8;
localparam int WORDS       = 2 ** ADDR_W;
localparam int N_DIRECT    = 16;
localparam int N_RAND      = 400;
localparam int TOTAL_REQ   = WORDS + N_DIRECT + N_RAND;
localparam int TIMEOUT_CYC = TOTAL_REQ * 40 + 1000;

logic                   clk;
logic                   rst;

// DUT ports
logic                   req_valid;
logic                   req_write;
logic [ADDR_W-1:0]      req_addr;
tcm_pkg::be_t           req_be;
tcm_pkg::data_t         req_wdata;
tcm_pkg::tag_t          req_tag;
logic                   req_credit;
logic                   rsp_valid;
logic                   rsp_ready;
tcm_pkg::tag_t          rsp_tag;
logic                   rsp_write;
tcm_pkg::data_t         rsp_data;

// Reference memory, expected responses in issue order
tcm_pkg::data_t         ref_mem   [WORDS];
tcm_pkg::tag_t          exp_tag_a [TOTAL_REQ + 1];
logic                   exp_wr_a  [TOTAL_REQ + 1];
tcm_pkg::data_t         exp_dat_a [TOTAL_REQ + 1];

// Issue side, owned by the stimulus process
int                     n_issued   = 0;
int                     issue_cyc  = 0;
int                     errors     = 0;
int                     stall_left = 0;
logic                   started    = 1'b0;
logic                   rand_ready = 1'b0;
tcm_pkg::tag_t          next_tag   = '0;

// Response side, owned by the monitor
int                     cyc        = 0;
int                     n_taken    = 0;
int                     n_credit   = 0;
logic                   prev_take  = 1'b0;
logic                   prev_stall = 1'b0;
logic                   head_ok;

tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clkgen (
        .o_clk          (clk),
        .o_rst          (rst)
);

tcm_top #(.ADDR_W(ADDR_W), .RSP_DEPTH(RSP_DEPTH)) u_tcm_top (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_req_valid    (req_valid),
        .i_req_write    (req_write),
        .i_req_addr     (req_addr),
        .i_req_be       (req_be),
        .i_req_wdata    (req_wdata),
        .i_req_tag      (req_tag),
        .o_req_credit   (req_credit),
        .o_rsp_valid    (rsp_valid),
        .i_rsp_ready    (rsp_ready),
        .o_rsp_tag      (rsp_tag),
        .o_rsp_write    (rsp_write),
        .o_rsp_data     (rsp_data)
);

// ------------------------------------------------------------
// Helpers
// ------------------------------------------------------------

task automatic report_value(input string name, input logic [31:0] expected,
                            input logic [31:0] got);
        errors++;
        $display("Fail %s: expected %h, got %h", name, expected, got);
endtask

task automatic report_problem(input string what);
        errors++;
        $display("Error: %s", what);
endtask

function automatic tcm_pkg::data_t rand_data();
        return $urandom;
endfunction

function automatic tcm_pkg::be_t rand_be();
        logic [31:0] r;
        r = $urandom;
        return r[tcm_pkg::BE_W-1:0];
endfunction

// Quarter of the time a hot set of four words, for near collisions
function automatic logic [ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $urandom;
        if (r[9:8] == 2'b00)
                return ADDR_W'(r[1:0]);
        return r[ADDR_W+1:2];
endfunction

// Step to 2 ns after the next edge, drop valid, pick ready
task automatic next_cycle();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        if (!rand_ready)
                rsp_ready = 1'b1;
        else if (stall_left > 0)
        begin
                rsp_ready = 1'b0;
                stall_left--;
        end
        else if ($urandom % 24 == 0)
        begin
                // Long stall, enough to fill the queue
                rsp_ready  = 1'b0;
                stall_left = 8 + int'($urandom % 24);
        end
        else
                rsp_ready = ($urandom % 4 != 0);
endtask

// One request for one cycle, only while a credit is held
task automatic issue_request(input logic write, input logic [ADDR_W-1:0] addr,
                             input tcm_pkg::be_t be, input tcm_pkg::data_t wdata);
        while (RSP_DEPTH + n_credit - n_issued == 0)
                next_cycle();
        assert (n_issued < TOTAL_REQ)
        else
                report_problem("more requests than planned");
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_be    = be;
        req_wdata = wdata;
        req_tag   = next_tag;
        started   = 1'b1;
        issue_cyc = cyc;
        exp_tag_a[n_issued] = next_tag;
        exp_wr_a[n_issued]  = write;
        // Model takes writes at issue, lane by lane
        if (write)
        begin
                for (int i = 0; i < tcm_pkg::BE_W; i++)
                begin
                        if (be[i])
                                ref_mem[addr][i*8 +: 8] = wdata[i*8 +: 8];
                end
                exp_dat_a[n_issued] = '0;
        end
        else
                exp_dat_a[n_issued] = ref_mem[addr];
        n_issued++;
        next_tag = tcm_pkg::tag_t'(next_tag + 1);
        next_cycle();
endtask

// All responses taken and all credits home
task automatic wait_drained();
        int guard;
        guard = 0;
        while ((n_taken != n_issued || n_credit != n_issued) && guard < 500)
        begin
                next_cycle();
                guard++;
        end
        assert (guard < 500)
        else
                report_problem($sformatf("drain stuck with %0d responses missing",
                                         n_issued - n_taken));
endtask

// ------------------------------------------------------------
// Monitor, sees values from before the edge
// ------------------------------------------------------------

always @(posedge clk)
begin
        cyc++;
        if (rst)
        begin
                prev_take  = 1'b0;
                prev_stall = 1'b0;
        end
        else
        begin
                prev_take  = rsp_valid && rsp_ready;
                prev_stall = rsp_valid && !rsp_ready;
                if (prev_take)
                        n_taken++;
                if (req_credit)
                        n_credit++;
        end
end

assign head_ok = rsp_valid && (n_taken < n_issued);

// ------------------------------------------------------------
// Checks at the falling edge, where everything is settled
// ------------------------------------------------------------

a_idle: assert property (@(negedge clk) disable iff (rst)
        !started |-> (!rsp_valid && !req_credit))
        else report_problem("response or credit seen before the first request");
a_known: assert property (@(negedge clk) disable iff (rst)
        rsp_valid |-> (n_taken < n_issued))
        else report_problem("response with no outstanding request");
a_tag: assert property (@(negedge clk) disable iff (rst)
        head_ok |-> (rsp_tag == exp_tag_a[n_taken]))
        else report_value("o_rsp_tag", 32'(exp_tag_a[n_taken]), 32'(rsp_tag));
a_write: assert property (@(negedge clk) disable iff (rst)
        head_ok |-> (rsp_write == exp_wr_a[n_taken]))
        else report_value("o_rsp_write", 32'(exp_wr_a[n_taken]), 32'(rsp_write));
// Write responses expect zero here
a_data: assert property (@(negedge clk) disable iff (rst)
        head_ok |-> (rsp_data == exp_dat_a[n_taken]))
        else report_value("o_rsp_data", exp_dat_a[n_taken], rsp_data);
a_hold: assert property (@(negedge clk) disable iff (rst)
        prev_stall |-> rsp_valid)
        else report_value("o_rsp_valid", 32'(1), 32'(rsp_valid));
// Exactly one credit, one cycle after each pop
a_credit: assert property (@(negedge clk) disable iff (rst)
        req_credit == prev_take)
        else report_value("o_req_credit", 32'(prev_take), 32'(req_credit));
a_balance: assert property (@(negedge clk) disable iff (rst)
        (RSP_DEPTH + n_credit - n_issued >= 0) && (RSP_DEPTH + n_credit - n_issued <= RSP_DEPTH))
        else report_problem("credit balance outside 0 to queue depth");

// Bounded by planned traffic
initial
begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, %0d of %0d responses taken",
                 TIMEOUT_CYC, n_taken, n_issued);
        $display("** FAIL **");
        $finish;
end

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------

initial
begin
        logic [31:0]            rnd;
        logic [ADDR_W-1:0]      addr;
        int                     guard;

        void'($urandom(32'hadb1));
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_be    = '0;
        req_wdata = '0;
        req_tag   = '0;
        rsp_ready = 1'b1;

        // Quiet period after reset
        while (rst)
                next_cycle();
        repeat (4)
                next_cycle();

        // Lone write into an empty queue, five cycle latency
        issue_request(1'b1, '0, '1, rand_data());
        guard = 0;
        while (!rsp_valid && guard < 20)
        begin
                next_cycle();
                guard++;
        end
        assert (cyc - issue_cyc == 5)
        else
                report_value("o_rsp_valid latency", 32'(5), 32'(cyc - issue_cyc));
        wait_drained();

        // Fill every word, contents start unknown
        for (int a = 0; a < WORDS; a++)
                issue_request(1'b1, ADDR_W'(a), '1, rand_data());

        // Lane merge across three partial writes
        issue_request(1'b1, 6'd5, 4'b1111, 32'h1122_3344);
        issue_request(1'b1, 6'd5, 4'b0101, 32'haabb_ccdd);
        issue_request(1'b1, 6'd5, 4'b1000, 32'h5566_7788);
        issue_request(1'b0, 6'd5, '0, '0);

        // Read one to four cycles behind a write, each RAM stage
        for (int gap = 1; gap <= 4; gap++)
        begin
                wait_drained();
                addr = rand_addr();
                issue_request(1'b1, addr, rand_be(), rand_data());
                repeat (gap - 1)
                        next_cycle();
                issue_request(1'b0, addr, '0, '0);
        end
        wait_drained();

        // Random mix under back-pressure
        rand_ready = 1'b1;
        for (int n = 0; n < N_RAND; n++)
        begin
                rnd = $urandom;
                if (rnd[1:0] == 2'b00)
                        next_cycle();
                issue_request(rnd[2], rand_addr(), rand_be(), rand_data());
        end
        rand_ready = 1'b0;
        wait_drained();

        // Final accounting
        assert (n_credit == n_taken && n_taken == n_issued)
        else
                report_problem($sformatf("%0d requests, %0d responses, %0d credits",
                                         n_issued, n_taken, n_credit));
        $display("Summary: %0d requests, %0d responses, %0d credits returned, %0d errors",
                 n_issued, n_taken, n_credit, errors);
        if (errors == 0)
                $display("** PASS **");
        else
                $display("** FAIL **");
        $finish;
end

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
// Testbench clock and reset source
// Free-running clock, synchronous reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
        parameter int PERIOD_NS  = 20,
        parameter int RST_CYCLES = 2
)
(
        output logic o_clk,
        output logic o_rst
);

// Clock toggles every half period
initial
begin
        o_clk = 1'b0;
        forever
        begin
                #(PERIOD_NS / 2);
                o_clk = ~o_clk;
        end
end

// Released shortly after an edge, like the other inputs
initial
begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #2;
        o_rst = 1'b0;
end

endmodule

`default_nettype wire

// ==== logic/tcm_top.sv ====
// TCM top level
// Credit-based request side, valid/ready response side
`timescale 1ns/1ps
`default_nettype none

module tcm_top #(
        parameter int ADDR_W    = tcm_pkg::ADDR_W_DEF,
        parameter int RSP_DEPTH = tcm_pkg::RSP_DEPTH_DEF
)
(
        input  logic                    i_clk,
        input  logic                    i_rst,

        // Request side
        input  logic                    i_req_valid,
        input  logic                    i_req_write,
        input  logic [ADDR_W-1:0]       i_req_addr,
        input  tcm_pkg::be_t            i_req_be,
        input  tcm_pkg::data_t          i_req_wdata,
        input  tcm_pkg::tag_t           i_req_tag,
        output logic                    o_req_credit,

        // Response side
        output logic                    o_rsp_valid,
        input  logic                    i_rsp_ready,
        output tcm_pkg::tag_t           o_rsp_tag,
        output logic                    o_rsp_write,
        output tcm_pkg::data_t          o_rsp_data
);

// ------------------------------------------------------------
// Internal nets
// ------------------------------------------------------------

// Pipe to RAM
tcm_req_if #(.ADDR_W(ADDR_W)) u_req_if ();

// RAM read data back into the pipe
tcm_pkg::data_t rd_data;

// Pipe to response queue
logic           push;
tcm_pkg::tag_t  push_tag;
logic           push_write;
tcm_pkg::data_t push_data;

// ------------------------------------------------------------
// Blocks
// ------------------------------------------------------------

tcm_access_pipe #(.ADDR_W(ADDR_W)) u_access_pipe (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_addr     (i_req_addr),
        .i_req_be       (i_req_be),
        .i_req_wdata    (i_req_wdata),
        .i_req_tag      (i_req_tag),
        .req            (u_req_if),
        .i_rd_data      (rd_data),
        .o_push         (push),
        .o_push_tag     (push_tag),
        .o_push_write   (push_write),
        .o_push_data    (push_data)
);

tcm_bypass_ram #(.ADDR_W(ADDR_W)) u_bypass_ram (
        .i_clk          (i_clk),
        .req            (u_req_if),
        .o_rd_data      (rd_data)
);

tcm_rsp_fifo #(.RSP_DEPTH(RSP_DEPTH)) u_rsp_fifo (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_push         (push),
        .i_push_write   (push_write),
        .i_push_tag     (push_tag),
        .i_push_data    (push_data),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_tag      (o_rsp_tag),
        .o_rsp_write    (o_rsp_write),
        .o_rsp_data     (o_rsp_data),
        .i_rsp_ready    (i_rsp_ready),
        .o_credit       (o_req_credit)
);

endmodule

`default_nettype wire

// ==== logic/tcm_rsp_fifo.sv ====
// TCM response queue
// Circular buffer with valid/ready head and one credit pulse per pop
`timescale 1ns/1ps
`default_nettype none

module tcm_rsp_fifo #(
        parameter int RSP_DEPTH = tcm_pkg::RSP_DEPTH_DEF
)
(
        input  logic            i_clk,
        input  logic            i_rst,
        input  logic            i_push,
        input  logic            i_push_write,
        input  tcm_pkg::tag_t   i_push_tag,
        input  tcm_pkg::data_t  i_push_data,
        output logic            o_rsp_valid,
        output tcm_pkg::tag_t   o_rsp_tag,
        output logic            o_rsp_write,
        output tcm_pkg::data_t  o_rsp_data,
        input  logic            i_rsp_ready,
        output logic            o_credit
);

localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
localparam int CNT_W = $clog2(RSP_DEPTH + 1);

// Entry storage
tcm_pkg::tag_t          tag_mem   [RSP_DEPTH];
logic                   write_mem [RSP_DEPTH];
tcm_pkg::data_t         data_mem  [RSP_DEPTH];

// Pointers and fill level
logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [CNT_W-1:0]       count;
logic                   pop;

// ------------------------------------------------------------
// Storage and head
// ------------------------------------------------------------

// Credits upstream guarantee a free slot on every push
always_ff @(posedge i_clk)
begin
        if (i_push)
        begin
                tag_mem[wr_ptr]   <= i_push_tag;
                write_mem[wr_ptr] <= i_push_write;
                data_mem[wr_ptr]  <= i_push_data;
        end
end

assign o_rsp_valid = (count != '0);
assign o_rsp_tag   = tag_mem[rd_ptr];
assign o_rsp_write = write_mem[rd_ptr];
assign o_rsp_data  = data_mem[rd_ptr];

// Head leaves on handshake
assign pop = o_rsp_valid && i_rsp_ready;

// ------------------------------------------------------------
// Control
// ------------------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_rst)
        begin
                wr_ptr   <= '0;
                rd_ptr   <= '0;
                count    <= '0;
                o_credit <= 1'b0;
        end
        else
        begin
                // Wrap at depth, which need not be a power of two
                if (i_push)
                        wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop)
                        rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

                // Fill level
                if (i_push && !pop)
                        count <= count + 1'b1;
                else if (!i_push && pop)
                        count <= count - 1'b1;

                // Slot freed, hand the credit back
                o_credit <= pop;
        end
end

endmodule

`default_nettype wire

// ==== logic/tcm_access_pipe.sv ====
// TCM access pipe
// Registers accepted requests, drives the RAM and carries tag and
// type of each access alongside the RAM read latency
`timescale 1ns/1ps
`default_nettype none

module tcm_access_pipe #(
        parameter int ADDR_W = tcm_pkg::ADDR_W_DEF
)
(
        input  logic                    i_clk,
        input  logic                    i_rst,
        input  logic                    i_req_valid,
        input  logic                    i_req_write,
        input  logic [ADDR_W-1:0]       i_req_addr,
        input  tcm_pkg::be_t            i_req_be,
        input  tcm_pkg::data_t          i_req_wdata,
        input  tcm_pkg::tag_t           i_req_tag,
        tcm_req_if.pipe                 req,
        input  tcm_pkg::data_t          i_rd_data,
        output logic                    o_push,
        output tcm_pkg::tag_t           o_push_tag,
        output logic                    o_push_write,
        output tcm_pkg::data_t          o_push_data
);

// Stage 0 is the registered request, stage 3 lines up with RAM data
localparam int STAGES = 4;

// Registered request payload
logic [ADDR_W-1:0]      addr_q;
tcm_pkg::be_t           be_q;
tcm_pkg::data_t         wdata_q;

// Per-access tracking shift
logic [STAGES-1:0]      vld_sh;
tcm_pkg::tag_t          tag_sh   [STAGES];
logic                   write_sh [STAGES];

// ------------------------------------------------------------
// Request capture
// ------------------------------------------------------------

// Payload, qualified by the valid shift
always_ff @(posedge i_clk)
begin
        addr_q  <= i_req_addr;
        be_q    <= i_req_be;
        wdata_q <= i_req_wdata;
end

// RAM drive, mask only for a valid write
assign req.wr_en   = (vld_sh[0] && write_sh[0]) ? be_q : '0;
assign req.wr_addr = addr_q;
assign req.wr_data = wdata_q;

// Every access reads, write data is dropped later
assign req.rd_addr = addr_q;

// ------------------------------------------------------------
// Tracking shift
// ------------------------------------------------------------

// Valid bits
always_ff @(posedge i_clk)
begin
        if (i_rst)
                vld_sh <= '0;
        else
                vld_sh <= {vld_sh[STAGES-2:0], i_req_valid};
end

// Tag and type, no reset needed behind valid
always_ff @(posedge i_clk)
begin
        tag_sh[0]   <= i_req_tag;
        write_sh[0] <= i_req_write;
        for (int s = 1; s < STAGES; s++)
        begin
                tag_sh[s]   <= tag_sh[s-1];
                write_sh[s] <= write_sh[s-1];
        end
end

// ------------------------------------------------------------
// Response push
// ------------------------------------------------------------

// Same cycle as RAM output
assign o_push       = vld_sh[STAGES-1];
assign o_push_tag   = tag_sh[STAGES-1];
assign o_push_write = write_sh[STAGES-1];

// Writes answer with zero data
assign o_push_data  = write_sh[STAGES-1] ? '0 : i_rd_data;

endmodule

`default_nettype wire

// ==== logic/tcm_bypass_ram.sv ====
// TCM byte-enable RAM
// Byte-lane array with a three-register read path
// Read data valid three edges after the read address is sampled
`timescale 1ns/1ps
`default_nettype none

module tcm_bypass_ram #(
        parameter int ADDR_W = tcm_pkg::ADDR_W_DEF
)
(
        input  logic            i_clk,
        tcm_req_if.ram          req,
        output tcm_pkg::data_t  o_rd_data
);

localparam int DEPTH = 2 ** ADDR_W;

// Storage
tcm_pkg::data_t mem [DEPTH];

// Read pipeline registers
tcm_pkg::data_t rd_data_st1;
tcm_pkg::data_t rd_data_st2;

// ------------------------------------------------------------
// Array write
// ------------------------------------------------------------

// Per-lane update that leaves disabled lanes untouched
always_ff @(posedge i_clk)
begin
        for (int i = 0; i < tcm_pkg::BE_W; i++)
        begin
                if (req.wr_en[i])
                        mem[req.wr_addr][i*8 +: 8] <= req.wr_data[i*8 +: 8];
        end
end

// ------------------------------------------------------------
// Stage 1 array read
// ------------------------------------------------------------

// Every earlier write reached the array at least one edge ago
// The only write in the same cycle is this access's own
always_ff @(posedge i_clk)
begin
        rd_data_st1 <= mem[req.rd_addr];
end

// ------------------------------------------------------------
// Stages 2 and 3
// ------------------------------------------------------------

// Retiming registers toward the output
always_ff @(posedge i_clk)
begin
        rd_data_st2 <= rd_data_st1;
        o_rd_data   <= rd_data_st2;
end

endmodule

`default_nettype wire

// ==== logic/tcm_req_if.sv ====
// TCM internal request bundle
// One registered access per cycle from the access pipe into the RAM
`timescale 1ns/1ps
`default_nettype none

interface tcm_req_if #(
        parameter int ADDR_W = tcm_pkg::ADDR_W_DEF
);

        // Byte write mask, all zero means no write
        tcm_pkg::be_t           wr_en;
        logic [ADDR_W-1:0]      wr_addr;
        tcm_pkg::data_t         wr_data;

        // Read address, presented for every access
        logic [ADDR_W-1:0]      rd_addr;

        // Access pipe drives the whole bundle
        modport pipe (
                output wr_en, wr_addr, wr_data, rd_addr
        );

        // RAM only listens
        modport ram (
                input wr_en, wr_addr, wr_data, rd_addr
        );

endinterface

`default_nettype wire

// ==== logic/tcm_pkg.sv ====
// TCM shared definitions
// Data, byte-enable and tag widths plus default sizes
`default_nettype none

package tcm_pkg;

        // ------------------------------------------------------------
        // Widths
        // ------------------------------------------------------------

        // Data word width in bits
        localparam int DATA_W = 32;

        // One enable per byte lane
        localparam int BE_W = DATA_W / 8;

        // Request tag, echoed back in the response
        localparam int TAG_W = 4;

        // ------------------------------------------------------------
        // Default sizes, overridden from the top level
        // ------------------------------------------------------------

        // Word address width, 64 words
        localparam int ADDR_W_DEF = 6;

        // Response queue entries, also the initial credit count
        localparam int RSP_DEPTH_DEF = 8;

        // ------------------------------------------------------------
        // Types
        // ------------------------------------------------------------

        typedef logic [DATA_W-1:0] data_t;
        typedef logic [BE_W-1:0]   be_t;
        typedef logic [TAG_W-1:0]  tag_t;

endpackage

`default_nettype wire
